// File: hw/dtcm_cfg.svh
// DTCM subsystem configuration
// Bus widths, RAM size, outstanding depth and light-sleep delay

`ifndef DTCM_CFG_SVH
`define DTCM_CFG_SVH

// Bus widths
`define DTCM_XLEN        32
`define DTCM_ADDR_SIZE   32

// 4 KiB RAM, word addressed
`define DTCM_RAM_AW      10

// Upper address bits compared against the PPI region
`define DTCM_PPI_RBITS   4

// Transactions in flight per tracker
`define DTCM_OUTS_DEPTH  2

// Idle cycles before the RAM enters light sleep
`define DTCM_LS_IDLE     8

`endif

// File: hw/icb_pkg.sv
// ICB bus payload types
// Command and response channel contents for every ICB link in the subsystem

`include "dtcm_cfg.svh"

package icb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Command channel
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [`DTCM_ADDR_SIZE-1:0] addr;   // Byte address
    logic                       read;   // 1 for load, 0 for store
    logic [`DTCM_XLEN-1:0]      wdata;
    logic [`DTCM_XLEN/8-1:0]    wmask;  // One bit per byte lane
  } icb_cmd_t;

  ////////////////////////////////////////////////////////////////////////////
  // Response channel
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                  err;
    logic [`DTCM_XLEN-1:0] rdata;  // Zero on stores
  } icb_rsp_t;

endpackage

// File: hw/tcm_pkg.sv
// Memory-side types for the DTCM
// SRAM request bundle plus the ids used to track outstanding transactions

`include "dtcm_cfg.svh"

package tcm_pkg;

  // Single-port RAM request, all fields sampled on the RAM clock edge
  typedef struct packed {
    logic                     cs;
    logic                     we;
    logic [`DTCM_RAM_AW-1:0]  addr;  // Word address
    logic [`DTCM_XLEN/8-1:0]  wem;   // Byte write enables
    logic [`DTCM_XLEN-1:0]    din;
  } sram_req_t;

  // Which master owns a DTCM transaction
  typedef enum logic {
    ARB_LSU = 1'b0,
    ARB_EXT = 1'b1
  } arb_id_e;

  // Which target a load/store went to
  typedef enum logic {
    ROUTE_DTCM = 1'b0,
    ROUTE_PPI  = 1'b1
  } route_e;

endpackage

// File: hw/id_fifo.sv
// Small in-order tracker FIFO
// Remembers the owner of each outstanding transaction so responses steer back

`timescale 1ns/1ps
`include "dtcm_cfg.svh"

module id_fifo #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  T     push_data,
  input  logic pop,
  output T     head,
  output logic empty,
  output logic full
);

  localparam int DEPTH = `DTCM_OUTS_DEPTH;
  localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW    = $clog2(DEPTH + 1);

  T                mem [DEPTH];
  logic [PW-1:0]   wptr, rptr;
  logic [CW-1:0]   count;

  assign head  = mem[rptr];
  assign empty = (count == '0);
  assign full  = (count == CW'(DEPTH));

  always_ff @(posedge clk) begin
    if (rst) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push) wptr <= (wptr == PW'(DEPTH - 1)) ? '0 : wptr + 1'b1;
      if (pop)  rptr <= (rptr == PW'(DEPTH - 1)) ? '0 : rptr + 1'b1;
      if (push && !pop)      count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (push) mem[wptr] <= push_data;
  end

endmodule

// File: hw/icb_splitter.sv
// Load/store ICB splitter
// Sends each command to the DTCM or the PPI by region, responses come back in order

`timescale 1ns/1ps
`include "dtcm_cfg.svh"

module icb_splitter
  import icb_pkg::*;
  import tcm_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`DTCM_ADDR_SIZE-1:0] ppi_region_indic,
  input  logic                       ppi_icb_enable,
  // Load/store unit side
  input  logic                       lsu_cmd_valid,
  output logic                       lsu_cmd_ready,
  input  icb_cmd_t                   lsu_cmd,
  output logic                       lsu_rsp_valid,
  input  logic                       lsu_rsp_ready,
  output icb_rsp_t                   lsu_rsp,
  // Toward the DTCM arbiter
  output logic                       dtcm_cmd_valid,
  input  logic                       dtcm_cmd_ready,
  output icb_cmd_t                   dtcm_cmd,
  input  logic                       dtcm_rsp_valid,
  output logic                       dtcm_rsp_ready,
  input  icb_rsp_t                   dtcm_rsp,
  // Private peripheral interface
  output logic                       ppi_cmd_valid,
  input  logic                       ppi_cmd_ready,
  output icb_cmd_t                   ppi_cmd,
  input  logic                       ppi_rsp_valid,
  output logic                       ppi_rsp_ready,
  input  icb_rsp_t                   ppi_rsp
);

  route_e route, head;
  logic   fifo_empty, fifo_full;
  logic   to_ppi, head_ppi;

  ////////////////////////////////////////////////////////////////////////////
  // Command path
  ////////////////////////////////////////////////////////////////////////////

  assign to_ppi = ppi_icb_enable &&
                  (lsu_cmd.addr[`DTCM_ADDR_SIZE-1 -: `DTCM_PPI_RBITS] ==
                   ppi_region_indic[`DTCM_ADDR_SIZE-1 -: `DTCM_PPI_RBITS]);
  assign route  = to_ppi ? ROUTE_PPI : ROUTE_DTCM;

  assign dtcm_cmd_valid = lsu_cmd_valid && !to_ppi && !fifo_full;
  assign ppi_cmd_valid  = lsu_cmd_valid &&  to_ppi && !fifo_full;
  assign dtcm_cmd       = lsu_cmd;  // Same payload to both, valid picks one
  assign ppi_cmd        = lsu_cmd;

  assign lsu_cmd_ready  = !fifo_full && (to_ppi ? ppi_cmd_ready : dtcm_cmd_ready);

  ////////////////////////////////////////////////////////////////////////////
  // Response path, steered by the oldest outstanding route
  ////////////////////////////////////////////////////////////////////////////

  assign head_ppi = (head == ROUTE_PPI);

  assign lsu_rsp_valid  = !fifo_empty && (head_ppi ? ppi_rsp_valid : dtcm_rsp_valid);
  assign lsu_rsp        = head_ppi ? ppi_rsp : dtcm_rsp;
  assign dtcm_rsp_ready = !fifo_empty && !head_ppi && lsu_rsp_ready;
  assign ppi_rsp_ready  = !fifo_empty &&  head_ppi && lsu_rsp_ready;

  id_fifo #(
    .T (route_e)
  ) route_fifo_i (
    .clk       (clk),
    .rst       (rst),
    .push      (lsu_cmd_valid && lsu_cmd_ready),
    .push_data (route),
    .pop       (lsu_rsp_valid && lsu_rsp_ready),
    .head      (head),
    .empty     (fifo_empty),
    .full      (fifo_full)
  );

endmodule

// File: hw/icb_arbiter.sv
// Round-robin DTCM arbiter
// Shares the DTCM between the load/store path and the external agent

`timescale 1ns/1ps

module icb_arbiter
  import icb_pkg::*;
  import tcm_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  // Load/store master
  input  logic     lsu_cmd_valid,
  output logic     lsu_cmd_ready,
  input  icb_cmd_t lsu_cmd,
  output logic     lsu_rsp_valid,
  input  logic     lsu_rsp_ready,
  output icb_rsp_t lsu_rsp,
  // External agent
  input  logic     ext_cmd_valid,
  output logic     ext_cmd_ready,
  input  icb_cmd_t ext_cmd,
  output logic     ext_rsp_valid,
  input  logic     ext_rsp_ready,
  output icb_rsp_t ext_rsp,
  // Toward the SRAM controller
  output logic     dtcm_cmd_valid,
  input  logic     dtcm_cmd_ready,
  output icb_cmd_t dtcm_cmd,
  input  logic     dtcm_rsp_valid,
  output logic     dtcm_rsp_ready,
  input  icb_rsp_t dtcm_rsp
);

  arb_id_e last_q, hold_id_q, grant, head;
  logic    hold_q;
  logic    fifo_empty, fifo_full;
  logic    cmd_hs;

  ////////////////////////////////////////////////////////////////////////////
  // Grant
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (hold_q)                              grant = hold_id_q;  // Stalled, keep winner
    else if (lsu_cmd_valid && ext_cmd_valid) grant = (last_q == ARB_LSU) ? ARB_EXT : ARB_LSU;
    else if (ext_cmd_valid)                  grant = ARB_EXT;
    else                                     grant = ARB_LSU;
  end

  assign dtcm_cmd_valid = (lsu_cmd_valid || ext_cmd_valid) && !fifo_full;
  assign dtcm_cmd       = (grant == ARB_EXT) ? ext_cmd : lsu_cmd;
  assign lsu_cmd_ready  = (grant == ARB_LSU) && !fifo_full && dtcm_cmd_ready;
  assign ext_cmd_ready  = (grant == ARB_EXT) && !fifo_full && dtcm_cmd_ready;
  assign cmd_hs         = dtcm_cmd_valid && dtcm_cmd_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      last_q    <= ARB_EXT;  // LSU wins the first tie
      hold_q    <= 1'b0;
      hold_id_q <= ARB_LSU;
    end else begin
      if (cmd_hs) last_q <= grant;
      hold_q    <= dtcm_cmd_valid && !dtcm_cmd_ready;
      hold_id_q <= grant;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response return
  ////////////////////////////////////////////////////////////////////////////

  assign lsu_rsp_valid  = dtcm_rsp_valid && !fifo_empty && (head == ARB_LSU);
  assign ext_rsp_valid  = dtcm_rsp_valid && !fifo_empty && (head == ARB_EXT);
  assign lsu_rsp        = dtcm_rsp;
  assign ext_rsp        = dtcm_rsp;
  assign dtcm_rsp_ready = !fifo_empty &&
                          ((head == ARB_LSU) ? lsu_rsp_ready : ext_rsp_ready);

  id_fifo #(
    .T (arb_id_e)
  ) owner_fifo_i (
    .clk       (clk),
    .rst       (rst),
    .push      (cmd_hs),
    .push_data (grant),
    .pop       (dtcm_rsp_valid && dtcm_rsp_ready),
    .head      (head),
    .empty     (fifo_empty),
    .full      (fifo_full)
  );

endmodule

// File: hw/dtcm_sram_ctrl.sv
// DTCM SRAM controller
// Turns ICB commands into single-port RAM cycles and registers the response

`timescale 1ns/1ps
`include "dtcm_cfg.svh"

module dtcm_sram_ctrl
  import icb_pkg::*;
  import tcm_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  input  icb_cmd_t              cmd,
  output logic                  rsp_valid,
  input  logic                  rsp_ready,
  output icb_rsp_t              rsp,
  input  logic                  dtcm_ls,
  output sram_req_t             dtcm_ram,
  input  logic [`DTCM_XLEN-1:0] dtcm_ram_dout,
  output logic                  dtcm_active
);

  logic                  cmd_hs, misalign;
  logic                  rsp_valid_q, fresh_q;  // fresh_q marks the dout cycle
  logic                  err_q, rd_q;
  logic [`DTCM_XLEN-1:0] rdata_q;

  assign misalign  = |cmd.addr[1:0];
  assign cmd_ready = !dtcm_ls && !(rsp_valid_q && !rsp_ready);
  assign cmd_hs    = cmd_valid && cmd_ready;

  // RAM request in the handshake cycle
  assign dtcm_ram.cs   = cmd_hs && !misalign;
  assign dtcm_ram.we   = !cmd.read;
  assign dtcm_ram.addr = cmd.addr[`DTCM_RAM_AW+1:2];
  assign dtcm_ram.wem  = cmd.wmask;
  assign dtcm_ram.din  = cmd.wdata;

  ////////////////////////////////////////////////////////////////////////////
  // Response register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid_q <= 1'b0;
      fresh_q     <= 1'b0;
    end else begin
      if (cmd_hs)         rsp_valid_q <= 1'b1;
      else if (rsp_ready) rsp_valid_q <= 1'b0;
      fresh_q <= cmd_hs;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_hs) begin
      err_q <= misalign;
      rd_q  <= cmd.read && !misalign;  // Only real loads carry data
    end
    if (fresh_q) rdata_q <= dtcm_ram_dout;  // Keep dout while stalled
  end

  assign rsp_valid = rsp_valid_q;
  assign rsp.err   = err_q;
  assign rsp.rdata = !rd_q   ? '0 :
                     fresh_q ? dtcm_ram_dout : rdata_q;

  assign dtcm_active = cmd_valid || rsp_valid_q;

endmodule

// File: hw/dtcm_ls_ctrl.sv
// DTCM light-sleep control
// Puts the RAM to sleep after a run of idle cycles, wakes it on a new request

`timescale 1ns/1ps
`include "dtcm_cfg.svh"

module dtcm_ls_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic dtcm_active,
  input  logic wake,
  output logic dtcm_ls
);

  localparam int CW = $clog2(`DTCM_LS_IDLE + 1);

  logic [CW-1:0] idle_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      idle_cnt <= '0;
      dtcm_ls  <= 1'b0;
    end else if (wake) begin
      idle_cnt <= '0;  // Leave sleep on the next edge
      dtcm_ls  <= 1'b0;
    end else if (dtcm_active) begin
      idle_cnt <= '0;
    end else if (idle_cnt != CW'(`DTCM_LS_IDLE)) begin
      idle_cnt <= idle_cnt + 1'b1;
      // Last idle cycle of the run
      if (idle_cnt == CW'(`DTCM_LS_IDLE - 1)) dtcm_ls <= 1'b1;
    end
  end

endmodule

// File: hw/dtcm_top.sv
// DTCM subsystem top
// Load/store splitter, DTCM arbiter, SRAM controller and light-sleep control

`timescale 1ns/1ps
`include "dtcm_cfg.svh"

module dtcm_top
  import icb_pkg::*;
  import tcm_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`DTCM_ADDR_SIZE-1:0] ppi_region_indic,
  input  logic                       ppi_icb_enable,
  // Load/store unit
  input  logic                       lsu_cmd_valid,
  output logic                       lsu_cmd_ready,
  input  icb_cmd_t                   lsu_cmd,
  output logic                       lsu_rsp_valid,
  input  logic                       lsu_rsp_ready,
  output icb_rsp_t                   lsu_rsp,
  // External agent
  input  logic                       ext_cmd_valid,
  output logic                       ext_cmd_ready,
  input  icb_cmd_t                   ext_cmd,
  output logic                       ext_rsp_valid,
  input  logic                       ext_rsp_ready,
  output icb_rsp_t                   ext_rsp,
  // Private peripheral interface
  output logic                       ppi_cmd_valid,
  input  logic                       ppi_cmd_ready,
  output icb_cmd_t                   ppi_cmd,
  input  logic                       ppi_rsp_valid,
  output logic                       ppi_rsp_ready,
  input  icb_rsp_t                   ppi_rsp,
  // RAM array outside the subsystem
  output sram_req_t                  dtcm_ram,
  input  logic [`DTCM_XLEN-1:0]      dtcm_ram_dout,
  output logic                       dtcm_ls
);

  logic     split_cmd_valid, split_cmd_ready, split_rsp_valid, split_rsp_ready;
  icb_cmd_t split_cmd;
  icb_rsp_t split_rsp;
  logic     arb_cmd_valid, arb_cmd_ready, arb_rsp_valid, arb_rsp_ready;
  icb_cmd_t arb_cmd;
  icb_rsp_t arb_rsp;
  logic     dtcm_active;

  icb_splitter splitter_i (
    .clk (clk), .rst (rst),
    .ppi_region_indic (ppi_region_indic), .ppi_icb_enable (ppi_icb_enable),
    .lsu_cmd_valid  (lsu_cmd_valid),   .lsu_cmd_ready  (lsu_cmd_ready),
    .lsu_cmd        (lsu_cmd),         .lsu_rsp_valid  (lsu_rsp_valid),
    .lsu_rsp_ready  (lsu_rsp_ready),   .lsu_rsp        (lsu_rsp),
    .dtcm_cmd_valid (split_cmd_valid), .dtcm_cmd_ready (split_cmd_ready),
    .dtcm_cmd       (split_cmd),       .dtcm_rsp_valid (split_rsp_valid),
    .dtcm_rsp_ready (split_rsp_ready), .dtcm_rsp       (split_rsp),
    .ppi_cmd_valid  (ppi_cmd_valid),   .ppi_cmd_ready  (ppi_cmd_ready),
    .ppi_cmd        (ppi_cmd),         .ppi_rsp_valid  (ppi_rsp_valid),
    .ppi_rsp_ready  (ppi_rsp_ready),   .ppi_rsp        (ppi_rsp)
  );

  icb_arbiter arbiter_i (
    .clk (clk), .rst (rst),
    .lsu_cmd_valid  (split_cmd_valid), .lsu_cmd_ready  (split_cmd_ready),
    .lsu_cmd        (split_cmd),       .lsu_rsp_valid  (split_rsp_valid),
    .lsu_rsp_ready  (split_rsp_ready), .lsu_rsp        (split_rsp),
    .ext_cmd_valid  (ext_cmd_valid),   .ext_cmd_ready  (ext_cmd_ready),
    .ext_cmd        (ext_cmd),         .ext_rsp_valid  (ext_rsp_valid),
    .ext_rsp_ready  (ext_rsp_ready),   .ext_rsp        (ext_rsp),
    .dtcm_cmd_valid (arb_cmd_valid),   .dtcm_cmd_ready (arb_cmd_ready),
    .dtcm_cmd       (arb_cmd),         .dtcm_rsp_valid (arb_rsp_valid),
    .dtcm_rsp_ready (arb_rsp_ready),   .dtcm_rsp       (arb_rsp)
  );

  dtcm_sram_ctrl sram_ctrl_i (
    .clk (clk), .rst (rst),
    .cmd_valid (arb_cmd_valid), .cmd_ready (arb_cmd_ready), .cmd (arb_cmd),
    .rsp_valid (arb_rsp_valid), .rsp_ready (arb_rsp_ready), .rsp (arb_rsp),
    .dtcm_ls (dtcm_ls), .dtcm_ram (dtcm_ram), .dtcm_ram_dout (dtcm_ram_dout),
    .dtcm_active (dtcm_active)
  );

  // Any arbitrated request wakes the RAM
  dtcm_ls_ctrl ls_ctrl_i (
    .clk (clk), .rst (rst),
    .dtcm_active (dtcm_active), .wake (arb_cmd_valid), .dtcm_ls (dtcm_ls)
  );

endmodule

// File: tb/tb_dtcm_top.sv
// Testbench for the DTCM subsystem
// Random ICB traffic on both masters, checked against a reference model

`timescale 1ns/1ps
`include "dtcm_cfg.svh"

module tb_dtcm_top
  import icb_pkg::*;
  import tcm_pkg::*;
();

  localparam int LIMIT = 4000;  // Twice the summed worst-case test lengths
  localparam int WORDS = 1 << `DTCM_RAM_AW;

  logic                       clk = 1'b0;
  logic                       rst;
  logic [`DTCM_ADDR_SIZE-1:0] ppi_region_indic;
  logic                       ppi_icb_enable;
  logic                       lsu_cmd_valid, lsu_cmd_ready, lsu_rsp_valid, lsu_rsp_ready;
  logic                       ext_cmd_valid, ext_cmd_ready, ext_rsp_valid, ext_rsp_ready;
  logic                       ppi_cmd_valid, ppi_cmd_ready, ppi_rsp_valid, ppi_rsp_ready;
  icb_cmd_t                   lsu_cmd, ext_cmd, ppi_cmd;
  icb_rsp_t                   lsu_rsp, ext_rsp, ppi_rsp;
  sram_req_t                  dtcm_ram;
  logic [`DTCM_XLEN-1:0]      dtcm_ram_dout = '0;
  logic                       dtcm_ls;

  logic [31:0]           rng_state = 32'd80238;
  logic [`DTCM_XLEN-1:0] ram [WORDS];      // Array behind the SRAM port
  logic [`DTCM_XLEN-1:0] ref_mem [WORDS];  // What the DTCM should hold
  icb_cmd_t              lsu_q[$], ext_q[$];
  icb_rsp_t              exp_lsu[$], exp_ext[$];
  logic [31:0]           ppi_pend[$];      // PPI addresses awaiting a response
  logic                  lsu_taken = 1'b0, ext_taken = 1'b0, ppi_taken = 1'b0;
  logic                  idle = 1'b0, stall_en = 1'b0, gap_en = 1'b0;
  int                    ppi_wait = 0, errors = 0, test_err = 0, cycles = 0;
  int                    n_lsu_cmd = 0, n_lsu_rsp = 0, n_ext_cmd = 0, n_ext_rsp = 0;

  dtcm_top dtcm_top_i (.*);

  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and model helpers
  ////////////////////////////////////////////////////////////////////////////

  function logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [31:0] fill_word(input int idx);
    return 32'hC0DE_0000 ^ (idx * 32'h9E37_79B1);
  endfunction

  // PPI read data follows the address
  function automatic logic [31:0] ppi_data(input logic [31:0] addr);
    return {addr[15:0], ~addr[31:16]};
  endfunction

  function automatic logic routes_to_ppi(input logic [31:0] addr);
    return ppi_icb_enable && (addr[31 -: `DTCM_PPI_RBITS] ==
                              ppi_region_indic[31 -: `DTCM_PPI_RBITS]);
  endfunction

  function automatic icb_cmd_t make_cmd(input logic [31:0] addr, input logic read,
                                        input logic [31:0] wdata, input logic [3:0] wmask);
    return '{addr: addr, read: read, wdata: wdata, wmask: wmask};
  endfunction

  // Mode 0 DTCM only, 1 mixed, 2 PPI region only
  function automatic icb_cmd_t rand_cmd(input int mode);
    logic [31:0] r;
    logic [31:0] addr;
    r    = next_rand();
    addr = 32'h8000_0000 | {r[5:2], 2'b00};  // 16 words shared by both masters
    if (mode == 2 || (mode == 1 && r[9:8] == 2'b00))
      addr = {ppi_region_indic[31:28], 20'h0, r[15:10], 2'b00};
    return make_cmd(addr, r[16], next_rand(), r[23:20]);
  endfunction

  // Applies one DTCM access to the reference memory and predicts its response
  function automatic icb_rsp_t dtcm_model(input icb_cmd_t c);
    icb_rsp_t                r;
    logic [`DTCM_RAM_AW-1:0] idx;
    r   = '0;
    idx = c.addr[`DTCM_RAM_AW+1:2];
    if (c.addr[1:0] != 2'b00) begin
      r.err = 1'b1;
    end else if (c.read) begin
      r.rdata = ref_mem[idx];
    end else begin
      for (int b = 0; b < 4; b++)
        if (c.wmask[b]) ref_mem[idx][8*b +: 8] = c.wdata[8*b +: 8];
    end
    return r;
  endfunction

  task automatic flag_error(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic check_rsp(input string name, input icb_rsp_t exp, input icb_rsp_t got);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s expected err=%0b rdata=%h actual err=%0b rdata=%h",
               $time, name, exp.err, exp.rdata, got.err, got.rdata);
    end
  endtask

  task automatic check_ppi_cmd(input string name, input icb_cmd_t exp, input icb_cmd_t got);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s expected %h actual %h", $time, name, exp, got);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s expected %b actual %b", $time, name, exp, got);
    end
  endtask

  task automatic wait_idle();
    do begin
      @(posedge clk);
    end while (!idle);
  endtask

  task automatic end_test(input string name);
    if (errors == test_err) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - test_err);
    test_err = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // RAM model, monitor and drivers
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (dtcm_ram.cs) begin
      if (dtcm_ram.we) begin
        for (int b = 0; b < 4; b++)
          if (dtcm_ram.wem[b]) ram[dtcm_ram.addr][8*b +: 8] <= dtcm_ram.din[8*b +: 8];
      end else begin
        dtcm_ram_dout <= ram[dtcm_ram.addr];  // Valid one cycle after cs
      end
    end
  end

  always @(posedge clk) begin : monitor
    icb_rsp_t pr;
    if (!rst) begin
      if (lsu_cmd_valid && lsu_cmd_ready) begin
        lsu_taken = 1'b1;
        n_lsu_cmd++;
        if (routes_to_ppi(lsu_cmd.addr)) begin
          if (!ppi_cmd_valid) flag_error("PPI-region command did not reach the PPI port");
          check_ppi_cmd("ppi_cmd", lsu_cmd, ppi_cmd);
          ppi_pend.push_back(lsu_cmd.addr);
          pr = '{err: lsu_cmd.addr[4], rdata: ppi_data(lsu_cmd.addr)};
          exp_lsu.push_back(pr);
        end else begin
          if (ppi_cmd_valid) flag_error("DTCM command also showed up at the PPI port");
          exp_lsu.push_back(dtcm_model(lsu_cmd));
        end
      end else if (ppi_cmd_valid && ppi_cmd_ready) begin
        flag_error("PPI accepted a command the load/store unit never issued");
      end
      if (ext_cmd_valid && ext_cmd_ready) begin
        ext_taken = 1'b1;
        n_ext_cmd++;
        exp_ext.push_back(dtcm_model(ext_cmd));
      end
      if (lsu_rsp_valid && lsu_rsp_ready) begin
        n_lsu_rsp++;
        if (exp_lsu.size() == 0) flag_error("load/store response with nothing outstanding");
        else check_rsp("lsu_rsp", exp_lsu.pop_front(), lsu_rsp);
      end
      if (ext_rsp_valid && ext_rsp_ready) begin
        n_ext_rsp++;
        if (exp_ext.size() == 0) flag_error("external response with nothing outstanding");
        else check_rsp("ext_rsp", exp_ext.pop_front(), ext_rsp);
      end
      if (ppi_rsp_valid && ppi_rsp_ready) ppi_taken = 1'b1;
    end
  end

  always @(negedge clk) begin : drive
    logic [31:0] paddr;
    if (lsu_taken) begin
      lsu_cmd_valid = 1'b0;
      lsu_taken     = 1'b0;
    end
    if (!lsu_cmd_valid && lsu_q.size() != 0 && (!gap_en || next_rand() % 3 != 0)) begin
      lsu_cmd       = lsu_q.pop_front();
      lsu_cmd_valid = 1'b1;
    end
    if (ext_taken) begin
      ext_cmd_valid = 1'b0;
      ext_taken     = 1'b0;
    end
    if (!ext_cmd_valid && ext_q.size() != 0 && (!gap_en || next_rand() % 3 != 0)) begin
      ext_cmd       = ext_q.pop_front();
      ext_cmd_valid = 1'b1;
    end
    lsu_rsp_ready = !stall_en || (next_rand() % 4 != 0);
    ext_rsp_ready = !stall_en || (next_rand() % 4 != 0);
    ppi_cmd_ready = !stall_en || (next_rand() % 3 != 0);
    // PPI responder, one response at a time after a random delay
    if (ppi_taken) begin
      ppi_rsp_valid = 1'b0;
      ppi_taken     = 1'b0;
    end
    if (!ppi_rsp_valid && ppi_pend.size() != 0) begin
      if (ppi_wait != 0) begin
        ppi_wait--;
      end else begin
        paddr         = ppi_pend.pop_front();
        ppi_rsp       = '{err: paddr[4], rdata: ppi_data(paddr)};
        ppi_rsp_valid = 1'b1;
        ppi_wait      = next_rand() % 4;
      end
    end
    idle = lsu_q.size() == 0 && ext_q.size() == 0 && !lsu_cmd_valid && !ext_cmd_valid &&
           exp_lsu.size() == 0 && exp_ext.size() == 0 && ppi_pend.size() == 0 &&
           !ppi_rsp_valid;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles == LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", LIMIT);
      $display("Regression failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst              = 1'b1;
    ppi_region_indic = 32'h1000_0000;
    ppi_icb_enable   = 1'b1;
    lsu_cmd_valid    = 1'b0;
    lsu_cmd          = '0;
    lsu_rsp_ready    = 1'b1;
    ext_cmd_valid    = 1'b0;
    ext_cmd          = '0;
    ext_rsp_ready    = 1'b1;
    ppi_cmd_ready    = 1'b1;
    ppi_rsp_valid    = 1'b0;
    ppi_rsp          = '0;
    for (int i = 0; i < WORDS; i++) begin
      ram[i]     = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    repeat (10) @(negedge clk);
    rst = 1'b0;

    // Sleep entry after reset, then wake by a command
    check_bit("dtcm_ls", 1'b0, dtcm_ls);
    repeat (`DTCM_LS_IDLE - 1) @(negedge clk);
    check_bit("dtcm_ls", 1'b0, dtcm_ls);
    @(negedge clk);
    check_bit("dtcm_ls", 1'b1, dtcm_ls);
    @(posedge clk);
    lsu_q.push_back(make_cmd(32'h8000_0040, 1'b0, next_rand(), 4'hF));
    lsu_q.push_back(make_cmd(32'h8000_0040, 1'b1, '0, '0));
    ext_q.push_back(make_cmd(32'h8000_0040, 1'b1, '0, '0));
    wait_idle();
    end_test("light sleep and wake");

    for (int i = 0; i < 24; i++) lsu_q.push_back(rand_cmd(0));
    wait_idle();
    end_test("load/store to DTCM");

    // Cross-master readback, then both masters at once
    for (int i = 0; i < 4; i++) begin
      ext_q.push_back(make_cmd(32'h8000_0080 + 4 * i, 1'b0, next_rand(), 4'hF));
      wait_idle();
      lsu_q.push_back(make_cmd(32'h8000_0080 + 4 * i, 1'b1, '0, '0));
      lsu_q.push_back(make_cmd(32'h8000_00C0 + 4 * i, 1'b0, next_rand(), 4'h5));
      wait_idle();
      ext_q.push_back(make_cmd(32'h8000_00C0 + 4 * i, 1'b1, '0, '0));
    end
    gap_en = 1'b1;
    for (int i = 0; i < 24; i++) begin
      lsu_q.push_back(rand_cmd(0));
      ext_q.push_back(rand_cmd(0));
    end
    wait_idle();
    gap_en = 1'b0;
    end_test("shared DTCM arbitration");

    for (int i = 0; i < 24; i++) lsu_q.push_back(rand_cmd(1));
    wait_idle();
    @(negedge clk);
    ppi_icb_enable = 1'b0;  // Region now falls through to the DTCM
    @(posedge clk);
    for (int i = 0; i < 8; i++) lsu_q.push_back(rand_cmd(2));
    wait_idle();
    @(negedge clk);
    ppi_icb_enable = 1'b1;
    end_test("PPI routing");

    @(posedge clk);
    lsu_q.push_back(make_cmd(32'h8000_0101, 1'b0, 32'hDEAD_BEEF, 4'hF));
    lsu_q.push_back(make_cmd(32'h8000_0102, 1'b1, '0, '0));
    ext_q.push_back(make_cmd(32'h8000_0103, 1'b0, 32'h1234_5678, 4'hF));
    wait_idle();
    lsu_q.push_back(make_cmd(32'h8000_0100, 1'b1, '0, '0));
    wait_idle();
    end_test("misaligned access");

    stall_en = 1'b1;
    gap_en   = 1'b1;
    for (int i = 0; i < 40; i++) begin
      lsu_q.push_back(rand_cmd(1));
      ext_q.push_back(rand_cmd(0));
    end
    wait_idle();
    stall_en = 1'b0;
    gap_en   = 1'b0;
    if (n_lsu_cmd != n_lsu_rsp || n_ext_cmd != n_ext_rsp)
      flag_error("command and response counts differ after the stall test");
    end_test("random stalls and delays");

    $display("Summary: %0d errors, lsu %0d cmds %0d rsps, ext %0d cmds %0d rsps",
             errors, n_lsu_cmd, n_lsu_rsp, n_ext_cmd, n_ext_rsp);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// File: tb.f
+incdir+hw
hw/icb_pkg.sv
hw/tcm_pkg.sv
hw/id_fifo.sv
hw/icb_splitter.sv
hw/icb_arbiter.sv
hw/dtcm_sram_ctrl.sv
hw/dtcm_ls_ctrl.sv
hw/dtcm_top.sv
tb/tb_dtcm_top.sv

// File: Bender.yml
package:
  name: dtcm_subsystem

sources:
  - include_dirs:
      - hw
    files:
      - hw/icb_pkg.sv
      - hw/tcm_pkg.sv
      - hw/id_fifo.sv
      - hw/icb_splitter.sv
      - hw/icb_arbiter.sv
      - hw/dtcm_sram_ctrl.sv
      - hw/dtcm_ls_ctrl.sv
      - hw/dtcm_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/tb_dtcm_top.sv
